//--- hdl/algebra_pkg.sv
// Algebra package
// Shared element types, dimension limits and controller state encoding
// for the integer matrix-product engine

`default_nettype none

package algebra_pkg;

  //////////////////////////////////////////////////
  // Dimensions
  //////////////////////////////////////////////////

  // Largest supported row or column count
  localparam int MAX_DIM = 4;

  //////////////////////////////////////////////////
  // Element types
  //////////////////////////////////////////////////

  // Input matrix element, two's complement
  typedef logic signed [15:0] data_t;
  // Product and result element, wraps modulo 2^32
  typedef logic signed [31:0] acc_t;
  // Matrix dimension, 1 to MAX_DIM
  typedef logic [2:0] dim_t;
  // Row or column position inside a stored matrix
  typedef logic [1:0] index_t;

  // One shift-add step per multiplier bit
  localparam int MAC_STEPS = $bits(data_t);

  //////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    STARTER,
    MATRIX_INPUT,
    VECTOR_MULTIPLIER,
    SCALAR_ADDER,
    OUTPUT_ELEMENT,
    MATRIX_UPDATE_J,
    MATRIX_UPDATE_I
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/scalar_op_if.sv
// Scalar operation link
// Start/ready handshake between the controller and the MAC unit

`timescale 1ns/100ps
`default_nettype none

interface scalar_op_if (
  input logic CLK
);
  import algebra_pkg::*;

  // One-cycle request, operands valid alongside
  logic  start;
  // Sampled with start, restart accumulation from zero
  logic  clear;
  data_t operand_a;
  data_t operand_b;

  // One-cycle completion pulse
  logic  ready;
  // Accumulator value, stable from ready until next start
  acc_t  result;

  // Requesting side
  modport ctrl (
    input  CLK,
    output start, clear, operand_a, operand_b,
    input  ready, result
  );

  // Arithmetic side
  modport mac (
    input  CLK,
    input  start, clear, operand_a, operand_b,
    output ready, result
  );

endinterface

`default_nettype wire

//--- hdl/matrix_buffer.sv
// Operand matrix buffer
// MAX_DIM x MAX_DIM register array, one registered write per strobe
// and one combinational read port

`timescale 1ns/100ps
`default_nettype none

module matrix_buffer (
  input  logic                CLK,
  input  logic                RST,
  // Write side, driven by the load counters
  input  logic                wr_en,
  input  algebra_pkg::index_t wr_row,
  input  algebra_pkg::index_t wr_col,
  input  algebra_pkg::data_t  wr_data,
  // Read side, driven by the compute indices
  input  algebra_pkg::index_t rd_row,
  input  algebra_pkg::index_t rd_col,
  output algebra_pkg::data_t  rd_data
);
  import algebra_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  data_t mem [MAX_DIM][MAX_DIM];

  // Row-major element store
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int r = 0; r < MAX_DIM; r++) begin
        for (int c = 0; c < MAX_DIM; c++) begin
          mem[r][c] <= '0;
        end
      end
    end else if (wr_en) begin
      mem[wr_row][wr_col] <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////

  // Same-cycle read, so the operand is valid with the MAC start pulse
  assign rd_data = mem[rd_row][rd_col];

endmodule

`default_nettype wire

//--- hdl/mac_unit.sv
// Multiply-accumulate unit
// Sequential signed shift-add multiplier on operand magnitudes,
// sign applied at the end, product added to a 32-bit wrapping accumulator

`timescale 1ns/100ps
`default_nettype none

module mac_unit (
  input logic         CLK,
  input logic         RST,
  scalar_op_if.mac    op
);
  import algebra_pkg::*;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Sequencing
  logic                               busy;
  logic [$clog2(MAC_STEPS+1)-1:0]     step;
  logic                               ready_q;
  acc_t                               acc;
  logic                               take;
  logic                               last_step;

  // Datapath
  logic [$bits(data_t)-1:0]           mag_a;
  logic [$bits(data_t)-1:0]           mag_b;
  logic [$bits(acc_t)-1:0]            mcand;
  logic [$bits(data_t)-1:0]           mplier;
  logic [$bits(acc_t)-1:0]            prod;
  logic                               sign_q;
  logic                               clear_q;
  acc_t                               signed_prod;

  // Unsigned magnitudes, -32768 maps onto 0x8000 correctly
  assign mag_a = op.operand_a[$bits(data_t)-1] ? unsigned'(-op.operand_a)
                                                : unsigned'(op.operand_a);
  assign mag_b = op.operand_b[$bits(data_t)-1] ? unsigned'(-op.operand_b)
                                                : unsigned'(op.operand_b);

  // New request only when idle
  assign take      = op.start && !busy;
  // Step counter saturates here for the accumulate cycle
  assign last_step = (step == MAC_STEPS[$bits(step)-1:0]);

  // Restore sign, magnitude product is at most 2^30
  assign signed_prod = sign_q ? -acc_t'(prod) : acc_t'(prod);

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  // 16 steps then one accumulate cycle, ready 17 cycles after start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy    <= 1'b0;
      step    <= '0;
      ready_q <= 1'b0;
      acc     <= '0;
    end else begin
      ready_q <= 1'b0;
      if (take) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        if (last_step) begin
          busy    <= 1'b0;
          ready_q <= 1'b1;
          // Plain adder, overflow wraps
          acc     <= (clear_q ? acc_t'(0) : acc) + signed_prod;
        end else begin
          step <= step + 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Shift-add datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (take) begin
      mcand   <= {{($bits(acc_t)-$bits(data_t)){1'b0}}, mag_a};
      mplier  <= mag_b;
      prod    <= '0;
      sign_q  <= op.operand_a[$bits(data_t)-1] ^ op.operand_b[$bits(data_t)-1];
      clear_q <= op.clear;
    end else if (busy && !last_step) begin
      // Add shifted multiplicand for each set multiplier bit
      if (mplier[0]) begin
        prod <= prod + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign op.ready  = ready_q;
  assign op.result = acc;

endmodule

`default_nettype wire

//--- hdl/matrix_product_ctrl.sv
// Matrix product controller
// Loads both operand streams, walks i/j/k through the MAC unit
// and streams C out in row-major order

`timescale 1ns/100ps
`default_nettype none

module matrix_product_ctrl (
  input  logic                CLK,
  input  logic                RST,
  // Run control
  input  logic                start,
  output logic                ready,
  input  algebra_pkg::dim_t   size_a_i,
  input  algebra_pkg::dim_t   size_a_j,
  input  algebra_pkg::dim_t   size_b_j,
  // Input stream strobes
  input  logic                data_a_in_i_enable,
  input  logic                data_a_in_j_enable,
  input  logic                data_b_in_i_enable,
  input  logic                data_b_in_j_enable,
  // Buffer writes
  output logic                a_wr_en,
  output algebra_pkg::index_t a_wr_row,
  output algebra_pkg::index_t a_wr_col,
  output logic                b_wr_en,
  output algebra_pkg::index_t b_wr_row,
  output algebra_pkg::index_t b_wr_col,
  // Buffer reads
  output algebra_pkg::index_t a_rd_row,
  output algebra_pkg::index_t a_rd_col,
  output algebra_pkg::index_t b_rd_row,
  output algebra_pkg::index_t b_rd_col,
  // Result stream
  output algebra_pkg::acc_t   data_out,
  output logic                data_out_i_enable,
  output logic                data_out_j_enable,
  // MAC request
  scalar_op_if.ctrl           op
);
  import algebra_pkg::*;

  // Element count, up to MAX_DIM squared
  typedef logic [2*$bits(dim_t)-1:0] count_t;

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ctrl_state_t state;

  // Sizes latched on start, size_k is the shared inner dimension
  dim_t   size_i, size_k, size_j;
  count_t a_total, b_total;

  // Load position and accepted element counts
  dim_t   a_row, a_col, b_row, b_col;
  dim_t   a_row_eff, a_col_eff, b_row_eff, b_col_eff;
  count_t a_cnt, b_cnt;
  logic   a_accept, b_accept;
  logic   load_done;

  // Compute indices
  index_t i, j, k;
  logic   i_last, j_last, k_last;

  // Row advance on i strobe, saturating past the largest matrix
  function automatic dim_t row_step(input dim_t row, input logic new_row);
    dim_t next;
    next = row;
    if (new_row && row < dim_t'(MAX_DIM)) begin
      next = row + dim_t'(1);
    end
    return next;
  endfunction

  //////////////////////////////////////////////////
  // Load addressing
  //////////////////////////////////////////////////

  // Position of the element carried by this strobe
  assign a_row_eff = row_step(a_row, data_a_in_i_enable);
  assign a_col_eff = data_a_in_i_enable ? dim_t'(0) : a_col;
  assign b_row_eff = row_step(b_row, data_b_in_i_enable);
  assign b_col_eff = data_b_in_i_enable ? dim_t'(0) : b_col;

  // Out-of-range elements dropped; B has size_k rows
  assign a_accept = (state == MATRIX_INPUT) && data_a_in_j_enable &&
                    (a_row_eff < size_i) && (a_col_eff < size_k);
  assign b_accept = (state == MATRIX_INPUT) && data_b_in_j_enable &&
                    (b_row_eff < size_k) && (b_col_eff < size_j);

  assign a_wr_en  = a_accept;
  assign a_wr_row = a_row_eff[$bits(index_t)-1:0];
  assign a_wr_col = a_col_eff[$bits(index_t)-1:0];
  assign b_wr_en  = b_accept;
  assign b_wr_row = b_row_eff[$bits(index_t)-1:0];
  assign b_wr_col = b_col_eff[$bits(index_t)-1:0];

  assign load_done = (a_cnt == a_total) && (b_cnt == b_total);

  //////////////////////////////////////////////////
  // Compute addressing
  //////////////////////////////////////////////////

  assign i_last = (dim_t'(i) == size_i - dim_t'(1));
  assign j_last = (dim_t'(j) == size_j - dim_t'(1));
  assign k_last = (dim_t'(k) == size_k - dim_t'(1));

  // A[i][k] times B[k][j]
  assign a_rd_row = i;
  assign a_rd_col = k;
  assign b_rd_row = k;
  assign b_rd_col = j;

  // Operands come straight from the buffer read ports
  assign op.start = (state == VECTOR_MULTIPLIER);
  assign op.clear = (k == '0);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= STARTER;
      size_i            <= '0;
      size_k            <= '0;
      size_j            <= '0;
      a_total           <= '0;
      b_total           <= '0;
      a_row             <= '0;
      a_col             <= '0;
      b_row             <= '0;
      b_col             <= '0;
      a_cnt             <= '0;
      b_cnt             <= '0;
      i                 <= '0;
      j                 <= '0;
      k                 <= '0;
      ready             <= 1'b0;
      data_out          <= '0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
    end else begin
      // Pulses by default
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;

      case (state)
        STARTER: begin
          // Only place a start is honoured
          if (start) begin
            size_i  <= size_a_i;
            size_k  <= size_a_j;
            size_j  <= size_b_j;
            a_total <= count_t'(size_a_i) * count_t'(size_a_j);
            b_total <= count_t'(size_a_j) * count_t'(size_b_j);
            a_row   <= '0;
            a_col   <= '0;
            b_row   <= '0;
            b_col   <= '0;
            a_cnt   <= '0;
            b_cnt   <= '0;
            i       <= '0;
            j       <= '0;
            k       <= '0;
            state   <= MATRIX_INPUT;
          end
        end

        MATRIX_INPUT: begin
          // A stream
          if (data_a_in_j_enable) begin
            a_row <= a_row_eff;
            a_col <= a_accept ? a_col_eff + dim_t'(1) : a_col_eff;
          end
          if (a_accept) begin
            a_cnt <= a_cnt + count_t'(1);
          end
          // B stream
          if (data_b_in_j_enable) begin
            b_row <= b_row_eff;
            b_col <= b_accept ? b_col_eff + dim_t'(1) : b_col_eff;
          end
          if (b_accept) begin
            b_cnt <= b_cnt + count_t'(1);
          end
          if (load_done) begin
            state <= VECTOR_MULTIPLIER;
          end
        end

        // Start pulse is issued for this single cycle
        VECTOR_MULTIPLIER: begin
          state <= SCALAR_ADDER;
        end

        SCALAR_ADDER: begin
          if (op.ready) begin
            if (k_last) begin
              state <= OUTPUT_ELEMENT;
            end else begin
              k     <= k + 1'b1;
              state <= VECTOR_MULTIPLIER;
            end
          end
        end

        OUTPUT_ELEMENT: begin
          data_out          <= op.result;
          data_out_j_enable <= 1'b1;
          // Row marker on column 0, row 0 included
          data_out_i_enable <= (j == '0);
          state             <= MATRIX_UPDATE_J;
        end

        MATRIX_UPDATE_J: begin
          k <= '0;
          if (!j_last) begin
            j     <= j + 1'b1;
            state <= VECTOR_MULTIPLIER;
          end else if (!i_last) begin
            state <= MATRIX_UPDATE_I;
          end else begin
            // Last element left on the previous edge
            ready <= 1'b1;
            state <= STARTER;
          end
        end

        MATRIX_UPDATE_I: begin
          j     <= '0;
          i     <= i + 1'b1;
          state <= VECTOR_MULTIPLIER;
        end

        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/matrix_product_top.sv
// Matrix product engine top level
// C = A x B on signed 16-bit elements with 32-bit wrapping results

`timescale 1ns/100ps
`default_nettype none

module matrix_product_top (
  input  logic              CLK,
  input  logic              RST,
  // Run control
  input  logic              start,
  output logic              ready,
  input  algebra_pkg::dim_t size_a_i,
  input  algebra_pkg::dim_t size_a_j,
  input  algebra_pkg::dim_t size_b_j,
  // Operand streams
  input  logic              data_a_in_i_enable,
  input  logic              data_a_in_j_enable,
  input  logic              data_b_in_i_enable,
  input  logic              data_b_in_j_enable,
  input  algebra_pkg::data_t data_a_in,
  input  algebra_pkg::data_t data_b_in,
  // Result stream
  output algebra_pkg::acc_t data_out,
  output logic              data_out_i_enable,
  output logic              data_out_j_enable
);
  import algebra_pkg::*;

  //////////////////////////////////////////////////
  // Wires
  //////////////////////////////////////////////////

  logic   a_wr_en, b_wr_en;
  index_t a_wr_row, a_wr_col, b_wr_row, b_wr_col;
  index_t a_rd_row, a_rd_col, b_rd_row, b_rd_col;

  // Controller to MAC link
  scalar_op_if op_bus (.CLK(CLK));

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  matrix_product_ctrl ctrl (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .size_a_i          (size_a_i),
    .size_a_j          (size_a_j),
    .size_b_j          (size_b_j),
    .data_a_in_i_enable(data_a_in_i_enable),
    .data_a_in_j_enable(data_a_in_j_enable),
    .data_b_in_i_enable(data_b_in_i_enable),
    .data_b_in_j_enable(data_b_in_j_enable),
    .a_wr_en           (a_wr_en),
    .a_wr_row          (a_wr_row),
    .a_wr_col          (a_wr_col),
    .b_wr_en           (b_wr_en),
    .b_wr_row          (b_wr_row),
    .b_wr_col          (b_wr_col),
    .a_rd_row          (a_rd_row),
    .a_rd_col          (a_rd_col),
    .b_rd_row          (b_rd_row),
    .b_rd_col          (b_rd_col),
    .data_out          (data_out),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .op                (op_bus.ctrl)
  );

  // A operand store, read port feeds the MAC directly
  matrix_buffer buffer_a (
    .CLK    (CLK),
    .RST    (RST),
    .wr_en  (a_wr_en),
    .wr_row (a_wr_row),
    .wr_col (a_wr_col),
    .wr_data(data_a_in),
    .rd_row (a_rd_row),
    .rd_col (a_rd_col),
    .rd_data(op_bus.operand_a)
  );

  // B operand store
  matrix_buffer buffer_b (
    .CLK    (CLK),
    .RST    (RST),
    .wr_en  (b_wr_en),
    .wr_row (b_wr_row),
    .wr_col (b_wr_col),
    .wr_data(data_b_in),
    .rd_row (b_rd_row),
    .rd_col (b_rd_col),
    .rd_data(op_bus.operand_b)
  );

  mac_unit mac (
    .CLK(CLK),
    .RST(RST),
    .op (op_bus.mac)
  );

endmodule

`default_nettype wire

//--- test/matrix_product_checker.sv
// Protocol checker for the matrix-product engine
// Bound into the top level, watches strobe pairing and handshake order

`timescale 1ns/100ps
`default_nettype none

module matrix_product_checker (
  input logic                     CLK,
  input logic                     RST,
  input logic                     start,
  input logic                     ready,
  input logic                     data_out_i_enable,
  input logic                     data_out_j_enable,
  input algebra_pkg::ctrl_state_t ctrl_state,
  input logic                     mac_start,
  input logic                     mac_ready
);
  import algebra_pkg::*;

  // Accepted start seen, first MAC request still pending
  logic wait_first_op;
  // MAC request in flight
  logic mac_busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wait_first_op <= 1'b0;
      mac_busy      <= 1'b0;
    end else begin
      if (start && ctrl_state == STARTER) begin
        wait_first_op <= 1'b1;
      end else if (mac_start) begin
        wait_first_op <= 1'b0;
      end
      if (mac_start) begin
        mac_busy <= 1'b1;
      end else if (mac_ready) begin
        mac_busy <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////

  row_marker_has_element: assert property (@(posedge CLK) disable iff (RST)
    data_out_i_enable |-> data_out_j_enable)
    else $error("Row marker without an element strobe");

  ready_single_cycle: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("ready held for more than one cycle");

  // Nothing leaves between the accepted start and the first MAC request
  quiet_before_first_op: assert property (@(posedge CLK) disable iff (RST)
    wait_first_op |-> !data_out_j_enable && !data_out_i_enable)
    else $error("Output strobe before the first MAC operation");

  mac_start_when_idle: assert property (@(posedge CLK) disable iff (RST)
    mac_busy |-> !mac_start)
    else $error("MAC start raised before the previous ready");

endmodule

bind matrix_product_top matrix_product_checker checker_inst (
  .CLK              (CLK),
  .RST              (RST),
  .start            (start),
  .ready            (ready),
  .data_out_i_enable(data_out_i_enable),
  .data_out_j_enable(data_out_j_enable),
  .ctrl_state       (ctrl.state),
  .mac_start        (op_bus.start),
  .mac_ready        (op_bus.ready)
);

`default_nettype wire

//--- test/matrix_product_tb.sv
// Matrix product engine testbench
// Streams random and structured operands through the engine and checks
// every element of C against a software matrix multiply

`timescale 1ns/100ps
`default_nettype none

module matrix_product_tb;
  import algebra_pkg::*;

  //////////////////////////////////////////////////
  // Run plan
  //////////////////////////////////////////////////

  localparam int NUM_RUNS       = 10;
  // A gapped 4x4 run needs about 1350 cycles
  localparam int RUN_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES;

  // Operand fill kinds
  localparam int FILL_RANDOM   = 0;
  localparam int FILL_EXTREME  = 1;
  localparam int FILL_IDENTITY = 2;
  localparam int FILL_KEEP     = 3;

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic  CLK;
  logic  RST;
  logic  start;
  logic  ready;
  dim_t  size_a_i;
  dim_t  size_a_j;
  dim_t  size_b_j;
  logic  data_a_in_i_enable;
  logic  data_a_in_j_enable;
  logic  data_b_in_i_enable;
  logic  data_b_in_j_enable;
  data_t data_a_in;
  data_t data_b_in;
  acc_t  data_out;
  logic  data_out_i_enable;
  logic  data_out_j_enable;

  // Operands and shape of the current run
  data_t mat_a [MAX_DIM][MAX_DIM];
  data_t mat_b [MAX_DIM][MAX_DIM];
  int    cur_i;
  int    cur_k;
  int    cur_j;

  // Run progress counters
  int          runs_started = 0;
  int          runs_done = 0;
  int          out_count = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr_state = 32'h7600_de37;

  matrix_product_top matrix_product_top_inst (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .size_a_i          (size_a_i),
    .size_a_j          (size_a_j),
    .size_b_j          (size_b_j),
    .data_a_in_i_enable(data_a_in_i_enable),
    .data_a_in_j_enable(data_a_in_j_enable),
    .data_b_in_i_enable(data_b_in_i_enable),
    .data_b_in_j_enable(data_b_in_j_enable),
    .data_a_in         (data_a_in),
    .data_b_in         (data_b_in),
    .data_out          (data_out),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable)
  );

  // 4 ns clock
  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int count, output logic [31:0] bits);
    bits = '0;
    for (int b = 0; b < count; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[31]};
    end
  endtask

  // Reference C[row][col] with 32-bit wrap
  function automatic acc_t ref_element(input int row, input int col);
    acc_t sum;
    sum = '0;
    for (int k = 0; k < cur_k; k++) begin
      sum = sum + acc_t'(mat_a[row][k]) * acc_t'(mat_b[k][col]);
    end
    return sum;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_element(input acc_t got, input acc_t expected);
    if (got !== expected) begin
      abort_run($sformatf("FAILED at %0t: run %0d element %0d of C is %0d, expected %0d",
                          $time, runs_done + 1, out_count, got, expected));
    end
  endtask

  task automatic check_row_start(input logic got, input logic expected);
    if (got !== expected) begin
      abort_run($sformatf("FAILED at %0t: run %0d element %0d row marker is %b, expected %b",
                          $time, runs_done + 1, out_count, got, expected));
    end
  endtask

  // Mostly the 16-bit extremes when asked for
  task automatic random_element(input logic extreme, output data_t value);
    logic [31:0] bits;
    take_bits($bits(data_t), bits);
    value = data_t'(bits[15:0]);
    if (extreme) begin
      take_bits(2, bits);
      case (bits[1:0])
        2'd0:    value = data_t'(16'h7fff);
        2'd1:    value = data_t'(16'h8000);
        2'd2:    value = data_t'(16'h8001);
        default: value = value;
      endcase
    end
  endtask

  task automatic fill_operands(input int fill);
    for (int r = 0; r < MAX_DIM; r++) begin
      for (int c = 0; c < MAX_DIM; c++) begin
        random_element(fill == FILL_EXTREME, mat_a[r][c]);
        if (fill == FILL_IDENTITY) begin
          mat_b[r][c] = (r == c) ? data_t'(1) : data_t'(0);
        end else begin
          random_element(fill == FILL_EXTREME, mat_b[r][c]);
        end
      end
    end
  endtask

  task automatic clear_strobes();
    data_a_in_i_enable = 1'b0;
    data_a_in_j_enable = 1'b0;
    data_b_in_i_enable = 1'b0;
    data_b_in_j_enable = 1'b0;
  endtask

  // Row-major streams with random gaps and optional trailing junk per row
  task automatic load_operands(input logic b_first, input logic extras);
    int          width_a;
    int          width_b;
    int          total_a;
    int          total_b;
    int          pos_a;
    int          pos_b;
    int          row;
    int          col;
    logic [31:0] bits;
    width_a = cur_k + int'(extras);
    width_b = cur_j + int'(extras);
    total_a = cur_i * width_a;
    total_b = cur_k * width_b;
    pos_a = 0;
    pos_b = 0;
    while (pos_a < total_a || pos_b < total_b) begin
      @(posedge CLK);
      #0.5;
      clear_strobes();
      // Two gate bits followed by filler data
      take_bits(18, bits);
      if (pos_a < total_a && !(b_first && pos_b < total_b) && bits[0]) begin
        row = pos_a / width_a;
        col = pos_a % width_a;
        data_a_in          = (col < cur_k) ? mat_a[row][col] : data_t'(bits[17:2]);
        data_a_in_i_enable = (col == 0) && (row != 0);
        data_a_in_j_enable = 1'b1;
        pos_a = pos_a + 1;
      end
      if (pos_b < total_b && bits[1]) begin
        row = pos_b / width_b;
        col = pos_b % width_b;
        data_b_in          = (col < cur_j) ? mat_b[row][col] : data_t'(bits[17:2]);
        data_b_in_i_enable = (col == 0) && (row != 0);
        data_b_in_j_enable = 1'b1;
        pos_b = pos_b + 1;
      end
    end
    @(posedge CLK);
    #0.5;
    clear_strobes();
  endtask

  task automatic drive_sizes(input int n_i, input int n_k, input int n_j);
    size_a_i = dim_t'(n_i);
    size_a_j = dim_t'(n_k);
    size_b_j = dim_t'(n_j);
  endtask

  task automatic run_product(input int n_i, input int n_k, input int n_j, input int fill,
                             input logic b_first, input logic extras, input logic mid_start);
    cur_i = n_i;
    cur_k = n_k;
    cur_j = n_j;
    if (fill != FILL_KEEP) begin
      fill_operands(fill);
    end
    @(posedge CLK);
    #0.5;
    start = 1'b1;
    drive_sizes(n_i, n_k, n_j);
    runs_started = runs_started + 1;
    @(posedge CLK);
    #0.5;
    start = 1'b0;
    load_operands(b_first, extras);
    if (mid_start) begin
      // Stray start with other sizes while the MAC is busy
      repeat (20) @(posedge CLK);
      #0.5;
      start = 1'b1;
      drive_sizes(MAX_DIM, MAX_DIM, MAX_DIM);
      @(posedge CLK);
      #0.5;
      start = 1'b0;
      drive_sizes(n_i, n_k, n_j);
    end
    // Wait for ready
    while (runs_done != runs_started) begin
      @(posedge CLK);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare and timeout
  //////////////////////////////////////////////////

  // Registered outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_j_enable) begin
        if (runs_done == runs_started) begin
          abort_run("An output element arrived while no run was in progress");
        end else if (out_count >= cur_i * cur_j) begin
          abort_run("An extra output arrived beyond the size of C");
        end else begin
          check_element(data_out, ref_element(out_count / cur_j, out_count % cur_j));
          check_row_start(data_out_i_enable, (out_count % cur_j) == 0);
          out_count = out_count + 1;
        end
      end
      if (ready) begin
        if (runs_done == runs_started) begin
          abort_run("ready pulsed while no run was in progress");
        end else if (out_count != cur_i * cur_j) begin
          abort_run("ready arrived before the expected outputs all appeared");
        end else begin
          out_count = 0;
          runs_done = runs_done + 1;
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles, the runs did not complete", cycle_count));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    RST       = 1'b1;
    start     = 1'b0;
    data_a_in = '0;
    data_b_in = '0;
    drive_sizes(1, 1, 1);
    clear_strobes();
    repeat (5) @(posedge CLK);
    #0.5;
    RST = 1'b0;
    // Idle window where any output is flagged
    repeat (10) @(posedge CLK);

    run_product(4, 4, 4, FILL_IDENTITY, 1'b0, 1'b0, 1'b0);
    run_product(4, 4, 4, FILL_EXTREME, 1'b0, 1'b0, 1'b0);
    run_product(4, 4, 4, FILL_RANDOM, 1'b0, 1'b0, 1'b0);
    // Same operands with the B stream first
    run_product(4, 4, 4, FILL_KEEP, 1'b1, 1'b0, 1'b0);
    run_product(2, 3, 4, FILL_RANDOM, 1'b0, 1'b1, 1'b0);
    run_product(1, 1, 1, FILL_EXTREME, 1'b0, 1'b0, 1'b0);
    // Outer product and then dot product with a stray start
    run_product(4, 1, 4, FILL_RANDOM, 1'b1, 1'b1, 1'b0);
    run_product(1, 4, 1, FILL_RANDOM, 1'b0, 1'b0, 1'b1);
    run_product(4, 4, 4, FILL_EXTREME, 1'b0, 1'b1, 1'b1);
    run_product(3, 4, 2, FILL_RANDOM, 1'b1, 1'b0, 1'b0);

    // Trailing window for stray strobes
    repeat (50) @(posedge CLK);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- matrix_product_top.f
hdl/algebra_pkg.sv
hdl/scalar_op_if.sv
hdl/matrix_buffer.sv
hdl/mac_unit.sv
hdl/matrix_product_ctrl.sv
hdl/matrix_product_top.sv
test/matrix_product_checker.sv
test/matrix_product_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the matrix product testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module matrix_product_tb \
  -f matrix_product_top.f \
  && ./obj_dir/Vmatrix_product_tb 2>&1 | tee sim.log

# Result decided by the log contents
grep -qx "test passed" sim.log && echo "run_sim: simulation ok" && exit 0 \
  || { echo "run_sim: simulation reported failure"; exit 1; }
